// ==== design/temporal_pkg.sv ====
package temporal_pkg;

    // a race-logic value is the phase at which a wire rises.
    localparam int TIME_WIDTH = 4;
    localparam int PHASE_WIDTH = 5;

    // one gamma cycle holds one phase per representable time.
    localparam int GAMMA_DEFAULT = 16;

    // clocks from an encoder phase match to the multiplexer output.
    localparam int PIPE_DEPTH = 3;

    typedef logic [TIME_WIDTH-1:0] race_time_t;

    // one bit wider than a time so the sequencer can count through the drain.
    typedef logic [PHASE_WIDTH-1:0] phase_t;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        run   = 2'd1,
        drain = 2'd2
    } seq_state_t;

endpackage

// ==== design/axil_pkg.sv ====
package axil_pkg;

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [DATA_WIDTH-1:0] axil_data_t;
    typedef logic [1:0]            axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // ====================
    // register map
    // ====================

    // bit 0 starts a run; reads back as zero.
    localparam axil_addr_t REG_CTRL = 8'h00;

    // bit 0 is busy, bit 1 is done.
    localparam axil_addr_t REG_STATUS = 8'h04;

    // select time in bits 3 down to 0, zero is not a legal select.
    localparam axil_addr_t REG_SELECT = 8'h08;

    // input i occupies bits 4i+3 down to 4i.
    localparam axil_addr_t REG_TIMES = 8'h0C;

    // sticky hit mask of the last run in the low bits.
    localparam axil_addr_t REG_HITS = 8'h10;

endpackage

// ==== design/binary2unary.sv ====
`timescale 1ns/1ps

module binary2unary (
    input  logic                     grst,
    input  logic                     aclk,
    input  logic                     gamma_start,
    input  temporal_pkg::race_time_t binary_input,
    output logic                     unary_output
);
    import temporal_pkg::*;

    phase_t phase;

    // the counter starts at zero in the clock after gamma_start and stops at
    // all ones, a value no time can reach, so a finished cycle stays quiet.
    always_ff @(posedge aclk, posedge grst) begin
        if (grst) begin
            phase        <= '1;
            unary_output <= 1'b0;
        end else if (gamma_start) begin
            phase        <= '0;
            unary_output <= 1'b0;
        end else begin
            if (phase != '1) begin
                phase <= phase + 1'b1;
            end
            // once high the edge stays high until the next gamma cycle.
            if (phase == phase_t'(binary_input)) begin
                unary_output <= 1'b1;
            end
        end
    end

endmodule

// ==== design/equal.sv ====
`timescale 1ns/1ps

module equal (
    input  logic grst,
    input  logic aclk,
    input  logic a,
    input  logic b,
    output logic y
);

    logic a_q;
    logic b_q;
    logic both_rise;

    // both temporal inputs must leave zero in the very same clock.
    assign both_rise = a && !a_q && b && !b_q;

    always_ff @(posedge aclk, posedge grst) begin
        if (grst) begin
            a_q <= 1'b0;
            b_q <= 1'b0;
            y   <= 1'b0;
        end else begin
            a_q <= a;
            b_q <= b;
            if (both_rise) begin
                y <= 1'b1;
            end else if (!a && !b) begin
                y <= 1'b0;
            end
        end
    end

endmodule

// ==== design/mux_t_be_t_N.sv ====
`timescale 1ns/1ps

module mux_t_be_t_N #(
    parameter int GAMMA_CYCLE_WIDTH = temporal_pkg::GAMMA_DEFAULT,
    parameter int NUM_INPUTS        = 8
) (
    input  logic                     grst,
    input  logic                     aclk,
    input  logic                     gamma_start,
    input  logic [NUM_INPUTS-1:0]    inputs,
    input  temporal_pkg::race_time_t select,
    output logic [NUM_INPUTS-1:0]    out
);
    import temporal_pkg::*;

    race_time_t            sel_early;
    logic                  unary_select;
    logic                  sel_d1;
    logic                  sel_d2;
    logic [NUM_INPUTS-1:0] inputs_q;

    // the select encoder is fed one phase early, so its edge leads the input
    // edges by one clock. zero wraps to the last phase of the gamma cycle.
    assign sel_early = (select == '0) ? race_time_t'(GAMMA_CYCLE_WIDTH - 1)
                                      : race_time_t'(select - 1'b1);

    binary2unary convertor (
        .grst         (grst),
        .aclk         (aclk),
        .gamma_start  (gamma_start),
        .binary_input (sel_early),
        .unary_output (unary_select)
    );

    // the extra select stage takes back the early start, so input time t
    // and select s meet in the equal gates exactly when t equals s.
    always_ff @(posedge aclk, posedge grst) begin
        if (grst) begin
            inputs_q <= '0;
            sel_d1   <= 1'b0;
            sel_d2   <= 1'b0;
        end else if (gamma_start) begin
            // a new gamma cycle drops the select edge at once, so every equal
            // gate sees both inputs low before the earliest input edge returns.
            inputs_q <= inputs;
            sel_d1   <= 1'b0;
            sel_d2   <= 1'b0;
        end else begin
            inputs_q <= inputs;
            sel_d1   <= unary_select;
            sel_d2   <= sel_d1;
        end
    end

    genvar i;
    generate
        for (i = 0; i < NUM_INPUTS; i++) begin : eq
            equal inst (
                .grst (grst),
                .aclk (aclk),
                .a    (sel_d2),
                .b    (inputs_q[i]),
                .y    (out[i])
            );
        end
    endgenerate

endmodule

// ==== design/race_sequencer.sv ====
`timescale 1ns/1ps

module race_sequencer #(
    parameter int GAMMA_CYCLE_WIDTH = temporal_pkg::GAMMA_DEFAULT,
    parameter int NUM_INPUTS        = 8
) (
    input  logic                  grst,
    input  logic                  aclk,
    input  logic                  start,
    output logic                  gamma_start,
    input  logic [NUM_INPUTS-1:0] mux_out,
    output logic                  busy,
    output logic                  done,
    output logic [NUM_INPUTS-1:0] hits
);
    import temporal_pkg::*;

    // the start clock is phase 0 of the gamma cycle.
    localparam phase_t LAST_RUN_PHASE  = phase_t'(GAMMA_CYCLE_WIDTH - 1);
    localparam phase_t LAST_PHASE      = phase_t'(GAMMA_CYCLE_WIDTH + PIPE_DEPTH);
    localparam phase_t FIRST_HIT_PHASE = phase_t'(PIPE_DEPTH + 1);

    seq_state_t state;
    phase_t     phase;
    logic       capture;

    assign gamma_start = start && (state == idle);

    // equal gates may still hold the previous run for a few clocks, so
    // capture opens only when a fresh coincidence can first appear.
    assign capture = (state != idle) && (phase >= FIRST_HIT_PHASE);

    // ====================
    // run control
    // ====================
    always_ff @(posedge aclk, posedge grst) begin
        if (grst) begin
            state <= idle;
            phase <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
            hits  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        phase <= phase_t'(1);
                        busy  <= 1'b1;
                        done  <= 1'b0;
                        hits  <= '0;
                    end
                end
                run: begin
                    phase <= phase + 1'b1;
                    if (phase == LAST_RUN_PHASE) begin
                        state <= drain;
                    end
                end
                drain: begin
                    // the last time value reaches the mask in this phase.
                    if (phase == LAST_PHASE) begin
                        state <= idle;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
            if (capture) begin
                hits <= hits | mux_out;
            end
        end
    end

endmodule

// ==== design/axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs #(
    parameter int NUM_INPUTS = 8
) (
    input  logic                     grst,
    input  logic                     aclk,
    input  axil_pkg::axil_addr_t     awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  axil_pkg::axil_data_t     wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output axil_pkg::axil_resp_t     bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  axil_pkg::axil_addr_t     araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output axil_pkg::axil_data_t     rdata,
    output axil_pkg::axil_resp_t     rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     start,
    output temporal_pkg::race_time_t select,
    output axil_pkg::axil_data_t     times,
    input  logic                     busy,
    input  logic                     done,
    input  logic [NUM_INPUTS-1:0]    hits
);
    import axil_pkg::*;
    import temporal_pkg::*;

    logic       wr_fire;
    logic       wr_err;
    race_time_t sel_next;
    logic       rd_fire;
    logic       rd_err;
    axil_data_t rd_value;

    function automatic axil_data_t merge_bytes(input axil_data_t old_value,
                                               input axil_data_t new_value,
                                               input logic [3:0] strb);
        axil_data_t merged;
        merged = old_value;
        for (int n = 0; n < 4; n++) begin
            if (strb[n]) begin
                merged[8*n +: 8] = new_value[8*n +: 8];
            end
        end
        return merged;
    endfunction

    // ====================
    // write channel
    // ====================

    // address and data are taken together, and only with no response pending.
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign sel_next = wstrb[0] ? race_time_t'(wdata[3:0]) : select;
    assign start    = wr_fire && (awaddr == REG_CTRL) && wstrb[0] && wdata[0] && !busy;

    always_comb begin
        case (awaddr)
            REG_CTRL:   wr_err = wstrb[0] && wdata[0] && busy;
            REG_SELECT: wr_err = (sel_next == '0);
            REG_TIMES:  wr_err = 1'b0;
            // status and hits are read only.
            default:    wr_err = 1'b1;
        endcase
    end

    // ====================
    // read channel
    // ====================
    assign rd_fire = arvalid && !rvalid;
    assign arready = !rvalid;

    always_comb begin
        rd_err   = 1'b0;
        rd_value = '0;
        case (araddr)
            REG_CTRL:   rd_value = '0;
            REG_STATUS: rd_value = axil_data_t'({done, busy});
            REG_SELECT: rd_value = axil_data_t'(select);
            REG_TIMES:  rd_value = times;
            REG_HITS:   rd_value = axil_data_t'(hits);
            default:    rd_err   = 1'b1;
        endcase
    end

    always_ff @(posedge aclk, posedge grst) begin
        if (grst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            select <= race_time_t'(1);
            times  <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (!wr_err && awaddr == REG_SELECT) begin
                    select <= sel_next;
                end
                if (!wr_err && awaddr == REG_TIMES) begin
                    times <= merge_bytes(times, wdata, wstrb);
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_fire) begin
            rdata <= rd_value;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// ==== design/temporal_select_top.sv ====
`timescale 1ns/1ps

module temporal_select_top #(
    parameter int GAMMA_CYCLE_WIDTH = temporal_pkg::GAMMA_DEFAULT,
    parameter int NUM_INPUTS        = 8
) (
    input  logic                 aclk,
    input  logic                 grst,
    input  axil_pkg::axil_addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  axil_pkg::axil_data_t wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output axil_pkg::axil_resp_t bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  axil_pkg::axil_addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output axil_pkg::axil_data_t rdata,
    output axil_pkg::axil_resp_t rresp,
    output logic                 rvalid,
    input  logic                 rready
);
    import temporal_pkg::*;
    import axil_pkg::*;

    logic                  start;
    logic                  gamma_start;
    race_time_t            select;
    axil_data_t            times;
    logic                  busy;
    logic                  done;
    logic [NUM_INPUTS-1:0] hits;
    logic [NUM_INPUTS-1:0] edges;
    logic [NUM_INPUTS-1:0] mux_out;

    axil_regs #(
        .NUM_INPUTS (NUM_INPUTS)
    ) u_regs (
        .grst    (grst),
        .aclk    (aclk),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .start   (start),
        .select  (select),
        .times   (times),
        .busy    (busy),
        .done    (done),
        .hits    (hits)
    );

    race_sequencer #(
        .GAMMA_CYCLE_WIDTH (GAMMA_CYCLE_WIDTH),
        .NUM_INPUTS        (NUM_INPUTS)
    ) u_seq (
        .grst        (grst),
        .aclk        (aclk),
        .start       (start),
        .gamma_start (gamma_start),
        .mux_out     (mux_out),
        .busy        (busy),
        .done        (done),
        .hits        (hits)
    );

    // each input time becomes one rising edge within the gamma cycle.
    genvar i;
    generate
        for (i = 0; i < NUM_INPUTS; i++) begin : enc
            binary2unary u_enc (
                .grst         (grst),
                .aclk         (aclk),
                .gamma_start  (gamma_start),
                .binary_input (times[i*TIME_WIDTH +: TIME_WIDTH]),
                .unary_output (edges[i])
            );
        end
    endgenerate

    mux_t_be_t_N #(
        .GAMMA_CYCLE_WIDTH (GAMMA_CYCLE_WIDTH),
        .NUM_INPUTS        (NUM_INPUTS)
    ) u_mux (
        .grst        (grst),
        .aclk        (aclk),
        .gamma_start (gamma_start),
        .inputs      (edges),
        .select      (select),
        .out         (mux_out)
    );

endmodule

// ==== include/tb_axil_tasks.svh ====
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// clocks a master waits for any single AXI handshake.
localparam int HANDSHAKE_LIMIT = 16;

// a nonzero hold keeps bready low for that many clocks once bvalid is seen,
// and offers the same write again meanwhile, which the slave must not take.
task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                         input axil_resp_t exp_resp, input int hold);
    int         waited;
    axil_resp_t first_resp;
    @(posedge aclk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    bready  <= (hold == 0);
    waited = 0;
    @(negedge aclk);
    while (!(awready && wready) && waited < HANDSHAKE_LIMIT) begin
        @(negedge aclk);
        waited++;
    end
    assert (awready && wready) else note_failure("write request was never accepted");
    @(posedge aclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    waited = 0;
    @(negedge aclk);
    while (!bvalid && waited < HANDSHAKE_LIMIT) begin
        @(negedge aclk);
        waited++;
    end
    assert (bvalid) else note_failure("no write response from the slave");
    first_resp = bresp;
    assert (bresp == exp_resp)
        else log_mismatch("bresp", axil_data_t'(bresp), axil_data_t'(exp_resp));
    if (hold != 0) begin
        @(posedge aclk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
    end
    for (int k = 0; k < hold; k++) begin
        @(negedge aclk);
        assert (bvalid && bresp == first_resp)
            else note_failure("write response was not held while bready was low");
    end
    if (hold != 0) begin
        @(posedge aclk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
    end
    @(posedge aclk);
endtask

// the same for reads, holding rready low for hold clocks while a second
// read waits at the slave.
task automatic read_reg(input axil_addr_t addr, input axil_resp_t exp_resp,
                        input int hold, output axil_data_t data);
    int waited;
    @(posedge aclk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= (hold == 0);
    waited = 0;
    @(negedge aclk);
    while (!arready && waited < HANDSHAKE_LIMIT) begin
        @(negedge aclk);
        waited++;
    end
    assert (arready) else note_failure("read request was never accepted");
    @(posedge aclk);
    arvalid <= 1'b0;
    waited = 0;
    @(negedge aclk);
    while (!rvalid && waited < HANDSHAKE_LIMIT) begin
        @(negedge aclk);
        waited++;
    end
    assert (rvalid) else note_failure("no read response from the slave");
    data = rdata;
    assert (rresp == exp_resp)
        else log_mismatch("rresp", axil_data_t'(rresp), axil_data_t'(exp_resp));
    if (hold != 0) begin
        @(posedge aclk);
        arvalid <= 1'b1;
    end
    for (int k = 0; k < hold; k++) begin
        @(negedge aclk);
        assert (rvalid && rdata == data)
            else note_failure("read data was not held while rready was low");
    end
    if (hold != 0) begin
        @(posedge aclk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
    end
    @(posedge aclk);
endtask

`endif

// ==== verification/tb_temporal_select.sv ====
`timescale 1ns/1ps

module tb_temporal_select;
    import temporal_pkg::*;
    import axil_pkg::*;

    localparam int GAMMA       = GAMMA_DEFAULT;
    localparam int NUM_INPUTS  = 8;
    localparam int CLK_PERIOD  = 20;
    localparam int RANDOM_RUNS = 27;
    localparam int POLL_LIMIT  = GAMMA + PIPE_DEPTH;

    // room for about forty runs with their register traffic.
    localparam int WATCHDOG_CLOCKS = 40 * (GAMMA + 20);

    logic       aclk;
    logic       grst;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;

    int          mismatches = 0;
    int          failures = 0;
    int          busy_clocks = 0;
    logic [15:0] lfsr_state = 16'd87;

    temporal_select_top #(
        .GAMMA_CYCLE_WIDTH (GAMMA),
        .NUM_INPUTS        (NUM_INPUTS)
    ) DUT (
        .aclk    (aclk),
        .grst    (grst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    function automatic void log_mismatch(input string name, input logic [31:0] got,
                                         input logic [31:0] exp);
        mismatches++;
        $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    endfunction

    function automatic void note_failure(input string what);
        failures++;
        $display("error at %0t ns: %s", $time, what);
    endfunction

    `include "tb_axil_tasks.svh"

    // ====================
    // stimulus source and model
    // ====================

    // 16-bit Fibonacci register, taps 16, 14, 13 and 11.
    function automatic logic lfsr_step();
        logic feedback;
        feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    function automatic axil_data_t take_bits(input int count);
        axil_data_t value;
        value = '0;
        for (int k = 0; k < count; k++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // an input hits when its time and the select time are the same phase.
    function automatic logic [NUM_INPUTS-1:0] expected_hits(input axil_data_t tv,
                                                            input race_time_t sel);
        logic [NUM_INPUTS-1:0] mask;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            mask[i] = (tv[4*i +: 4] == sel);
        end
        return mask;
    endfunction

    task automatic check_reg(input axil_addr_t addr, input axil_data_t exp_value,
                             input string name);
        axil_data_t value;
        read_reg(addr, RESP_OKAY, 0, value);
        assert (value == exp_value) else log_mismatch(name, value, exp_value);
    endtask

    task automatic launch_run(input race_time_t sel, input axil_data_t tv);
        write_reg(REG_SELECT, axil_data_t'(sel), RESP_OKAY, 0);
        write_reg(REG_TIMES, tv, RESP_OKAY, 0);
        write_reg(REG_CTRL, 32'h1, RESP_OKAY, 0);
    endtask

    task automatic wait_done(input logic [NUM_INPUTS-1:0] exp_mask);
        axil_data_t status;
        int         polls;
        status = '0;
        polls = 0;
        while (!status[1] && polls < POLL_LIMIT) begin
            read_reg(REG_STATUS, RESP_OKAY, 0, status);
            polls++;
        end
        assert (status[1]) else note_failure("done never appeared in REG_STATUS");
        check_reg(REG_HITS, axil_data_t'(exp_mask), "REG_HITS");
        check_reg(REG_STATUS, 32'h2, "REG_STATUS");
    endtask

    task automatic run_case(input race_time_t sel, input axil_data_t tv);
        launch_run(sel, tv);
        check_reg(REG_STATUS, 32'h1, "REG_STATUS");
        wait_done(expected_hits(tv, sel));
    endtask

    task automatic random_case();
        race_time_t sel;
        axil_data_t tv;
        axil_data_t draw;
        draw = take_bits(4);
        sel = race_time_t'(draw % 15 + 1);
        tv = '0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            // about half the inputs are steered onto the select so hits are common.
            draw = take_bits(1);
            if (draw[0]) begin
                tv[4*i +: 4] = sel;
            end else begin
                draw = take_bits(4);
                tv[4*i +: 4] = draw[3:0];
            end
        end
        run_case(sel, tv);
    endtask

    // ====================
    // protocol and status properties
    // ====================
    assert property (@(posedge aclk) disable iff (grst)
                     bvalid && !bready |=> bvalid && $stable(bresp))
        else note_failure("write response dropped or changed under back-pressure");
    assert property (@(posedge aclk) disable iff (grst)
                     rvalid && !rready |=> rvalid && $stable(rdata))
        else note_failure("read response dropped or changed under back-pressure");
    assert property (@(posedge aclk) disable iff (grst) bvalid |-> !awready)
        else note_failure("write accepted while a write response was pending");
    assert property (@(posedge aclk) disable iff (grst) rvalid |-> !arready)
        else note_failure("read accepted while a read response was pending");
    assert property (@(posedge aclk) disable iff (grst) $fell(DUT.done) |-> DUT.busy)
        else note_failure("done cleared without a new run starting");

    // a run must stay busy for exactly one gamma cycle plus the pipeline.
    always @(negedge aclk) begin
        if (grst) begin
            busy_clocks = 0;
        end else if (DUT.busy) begin
            busy_clocks++;
            assert (!DUT.done) else note_failure("done was set while busy");
        end else if (busy_clocks != 0) begin
            assert (busy_clocks == GAMMA + PIPE_DEPTH)
                else log_mismatch("busy_clocks", busy_clocks, GAMMA + PIPE_DEPTH);
            assert (DUT.done) else note_failure("done did not set when busy fell");
            busy_clocks = 0;
        end
    end

    initial begin
        #(WATCHDOG_CLOCKS * CLK_PERIOD);
        $display("watchdog expired after %0d clocks: %0d mismatches, %0d other errors",
                 WATCHDOG_CLOCKS, mismatches, failures);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ====================
    // test sequence
    // ====================
    initial begin
        axil_data_t value;
        aclk    = 1'b0;
        grst    = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(posedge aclk);
        grst <= 1'b0;

        check_reg(REG_STATUS, '0, "REG_STATUS");
        check_reg(REG_HITS, '0, "REG_HITS");

        write_reg(REG_SELECT, 32'h5, RESP_OKAY, 0);
        check_reg(REG_SELECT, 32'h5, "REG_SELECT");
        write_reg(REG_TIMES, 32'h89AB_CDEF, RESP_OKAY, 0);
        check_reg(REG_TIMES, 32'h89AB_CDEF, "REG_TIMES");

        write_reg(REG_SELECT, 32'h0, RESP_SLVERR, 0);
        check_reg(REG_SELECT, 32'h5, "REG_SELECT");
        write_reg(8'h20, 32'hFFFF_FFFF, RESP_SLVERR, 0);
        check_reg(REG_TIMES, 32'h89AB_CDEF, "REG_TIMES");
        check_reg(REG_SELECT, 32'h5, "REG_SELECT");
        read_reg(8'h24, RESP_SLVERR, 0, value);

        write_reg(REG_TIMES, 32'h1234_5678, RESP_OKAY, 4);
        read_reg(REG_TIMES, RESP_OKAY, 4, value);
        assert (value == 32'h1234_5678) else log_mismatch("rdata", value, 32'h1234_5678);

        run_case(4'd7, 32'h0123_4568);
        run_case(4'd3, 32'h0123_4568);
        run_case(4'd9, 32'h9999_9999);
        for (int n = 0; n < RANDOM_RUNS; n++) begin
            random_case();
        end

        // a second start during the run is refused and the run finishes as set up.
        launch_run(4'd2, 32'h2222_0000);
        write_reg(REG_CTRL, 32'h1, RESP_SLVERR, 0);
        check_reg(REG_SELECT, 32'h2, "REG_SELECT");
        check_reg(REG_TIMES, 32'h2222_0000, "REG_TIMES");
        wait_done(8'hF0);

        @(posedge aclk);
        grst <= 1'b1;
        repeat (3) @(posedge aclk);
        grst <= 1'b0;
        check_reg(REG_STATUS, '0, "REG_STATUS");
        check_reg(REG_HITS, '0, "REG_HITS");

        $display("checks complete: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
design/temporal_pkg.sv
design/axil_pkg.sv
design/binary2unary.sv
design/equal.sv
design/mux_t_be_t_N.sv
design/race_sequencer.sv
design/axil_regs.sv
design/temporal_select_top.sv
verification/tb_temporal_select.sv
